// File: logic/sspim_config.svh
// Fixed build constants; only address bits 3:2 are decoded and the chip select count is fixed at 4
`ifndef SSPIM_CONFIG_SVH
`define SSPIM_CONFIG_SVH

// ----------------------------------------------------------
// Register byte offsets, 0xC reads as zero
// ----------------------------------------------------------
`define SSPIM_REG_CTRL      8'h00
`define SSPIM_REG_DIN       8'h04
`define SSPIM_REG_DOUT      8'h08

// Chip select lines on the pins
`define SSPIM_NUM_CS        4

// ----------------------------------------------------------
// Control word field positions
// ----------------------------------------------------------
`define SSPIM_CTRL_REQ      31
`define SSPIM_CTRL_TGT_HI   24
`define SSPIM_CTRL_TGT_LO   23
`define SSPIM_CTRL_OP_HI    22
`define SSPIM_CTRL_OP_LO    21
`define SSPIM_CTRL_SIZE_HI  20
`define SSPIM_CTRL_SIZE_LO  19
`define SSPIM_CTRL_SCK_HI   18
`define SSPIM_CTRL_SCK_LO   13
`define SSPIM_CTRL_CS_HI    12
`define SSPIM_CTRL_CS_LO    8

// Writable control bits, request bit handled on its own
`define SSPIM_CTRL_WMASK    32'h01FF_FF00

// Reset values
`define SSPIM_CTRL_RST      32'h0000_0000
`define SSPIM_DIN_RST       32'h0000_0000
`define SSPIM_DOUT_RST      32'h0000_0000

`endif

// File: logic/sspim_pkg.sv
// Types shared by the SPI master blocks; op code 2'b11 is not named and acts as full duplex
package sspim_pkg;

  // ----------------------------------------------------------
  // Operation codes from the control word
  // ----------------------------------------------------------
  typedef enum logic [1:0] {
    // Transmit only
    op_wr    = 2'b00,
    // Zeros out, miso captured
    op_rd    = 2'b01,
    // Full duplex
    op_wr_rd = 2'b10
  } sspim_op_e;

  // Controller states
  typedef enum logic [2:0] {
    st_idle     = 3'd0,
    st_cs_setup = 3'd1,
    st_xfer     = 3'd2,
    st_cs_hold  = 3'd3,
    st_done     = 3'd4
  } sspim_state_e;

  // ----------------------------------------------------------
  // Configuration seen by the controller and shifter
  // ----------------------------------------------------------
  typedef struct packed {
    logic [1:0] tgt_sel;
    sspim_op_e  op;
    // Bytes minus one
    logic [1:0] xfer_size;
    // Half period of sck minus one, in mclk cycles
    logic [5:0] sck_period;
    // CS setup and hold minus one
    logic [4:0] cs_period;
  } sspim_cfg_t;

  // One-cycle sck events, valid in the cycle before sck changes
  typedef struct packed {
    logic sck_rise;
    logic sck_fall;
  } sspim_edge_t;

  // Shifter commands
  typedef struct packed {
    logic load;
    logic shift_out;
    logic sample;
  } sspim_shift_t;

endpackage

// File: logic/sspim_cfg.sv
// Register block; accesses are acked two edges after reg_cs is sampled and must be held until ack
`include "sspim_config.svh"

module sspim_cfg (
  input  logic                  mclk,
  input  logic                  reset_n,
  input  logic                  reg_cs,
  input  logic                  reg_wr,
  input  logic [7:0]            reg_addr,
  input  logic [31:0]           reg_wdata,
  input  logic [3:0]            reg_be,
  input  logic                  op_done,
  input  logic [31:0]           rx_data,
  output logic [31:0]           reg_rdata,
  output logic                  reg_ack,
  output sspim_pkg::sspim_cfg_t cfg,
  output logic                  op_req,
  output logic [31:0]           tx_data
);
  import sspim_pkg::*;

  localparam logic [7:0]  ctrl_off   = `SSPIM_REG_CTRL;
  localparam logic [7:0]  din_off    = `SSPIM_REG_DIN;
  localparam logic [7:0]  dout_off   = `SSPIM_REG_DOUT;
  localparam logic [31:0] ctrl_wmask = `SSPIM_CTRL_WMASK;

  logic        sw_rd_en;
  logic        sw_wr_en;
  logic        reg_cs_l;
  logic        reg_cs_2l;
  logic [1:0]  sw_idx;
  logic [31:0] sw_wdata;
  logic [3:0]  sw_be;
  logic        acc_ok;
  logic        wr_stb;
  logic        rd_stb;
  logic        ctrl_wr;
  logic        din_wr;
  logic [31:0] ctrl_q;
  logic [31:0] din_q;
  logic [31:0] ctrl_rd;
  logic [31:0] rd_mux;
  logic        req_q;

  // ----------------------------------------------------------
  // Bus request registered first
  // ----------------------------------------------------------
  always_ff @(posedge mclk or negedge reset_n) begin
    if (!reset_n) begin
      sw_rd_en  <= 1'b0;
      sw_wr_en  <= 1'b0;
      reg_cs_l  <= 1'b0;
      reg_cs_2l <= 1'b0;
    end else begin
      sw_rd_en  <= reg_cs & ~reg_wr;
      sw_wr_en  <= reg_cs & reg_wr;
      reg_cs_l  <= reg_cs;
      reg_cs_2l <= reg_cs_l;
    end
  end

  // Address, data and strobes
  always_ff @(posedge mclk) begin
    sw_idx   <= reg_addr[3:2];
    sw_wdata <= reg_wdata;
    sw_be    <= reg_be;
  end

  // One access per held request; reg_cs_2l blocks a repeat while cs drains
  assign acc_ok  = ~reg_ack & ~reg_cs_2l;
  assign wr_stb  = sw_wr_en & acc_ok;
  assign rd_stb  = sw_rd_en & acc_ok;
  assign ctrl_wr = wr_stb & (sw_idx == ctrl_off[3:2]);
  assign din_wr  = wr_stb & (sw_idx == din_off[3:2]);

  // ----------------------------------------------------------
  // Control and data-in registers, byte enabled
  // ----------------------------------------------------------
  always_ff @(posedge mclk or negedge reset_n) begin
    if (!reset_n) begin
      ctrl_q <= `SSPIM_CTRL_RST;
      din_q  <= `SSPIM_DIN_RST;
    end else begin
      for (int b = 0; b < 4; b++) begin
        // Unused control bits stay zero
        if (ctrl_wr && sw_be[b]) begin
          ctrl_q[8*b +: 8] <= sw_wdata[8*b +: 8] & ctrl_wmask[8*b +: 8];
        end
        if (din_wr && sw_be[b]) begin
          din_q[8*b +: 8] <= sw_wdata[8*b +: 8];
        end
      end
    end
  end

  // Request bit, set by software, cleared by op_done
  always_ff @(posedge mclk or negedge reset_n) begin
    if (!reset_n) begin
      req_q <= 1'b0;
    end else if (op_done) begin
      req_q <= 1'b0;
    end else if (ctrl_wr && sw_be[3] && sw_wdata[`SSPIM_CTRL_REQ]) begin
      req_q <= 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Read path
  // ----------------------------------------------------------
  always_comb begin
    ctrl_rd = ctrl_q;
    ctrl_rd[`SSPIM_CTRL_REQ] = req_q;
  end

  always_comb begin
    case (sw_idx)
      ctrl_off[3:2]: rd_mux = ctrl_rd;
      din_off[3:2]:  rd_mux = din_q;
      dout_off[3:2]: rd_mux = rx_data;
      default:       rd_mux = '0;
    endcase
  end

  // Ack for one cycle, read data valid with it
  always_ff @(posedge mclk or negedge reset_n) begin
    if (!reset_n) begin
      reg_ack   <= 1'b0;
      reg_rdata <= '0;
    end else begin
      reg_ack <= rd_stb | wr_stb;
      if (rd_stb) begin
        reg_rdata <= rd_mux;
      end
    end
  end

  // Fields out to the controller
  assign cfg.tgt_sel    = ctrl_q[`SSPIM_CTRL_TGT_HI:`SSPIM_CTRL_TGT_LO];
  assign cfg.op         = sspim_op_e'(ctrl_q[`SSPIM_CTRL_OP_HI:`SSPIM_CTRL_OP_LO]);
  assign cfg.xfer_size  = ctrl_q[`SSPIM_CTRL_SIZE_HI:`SSPIM_CTRL_SIZE_LO];
  assign cfg.sck_period = ctrl_q[`SSPIM_CTRL_SCK_HI:`SSPIM_CTRL_SCK_LO];
  assign cfg.cs_period  = ctrl_q[`SSPIM_CTRL_CS_HI:`SSPIM_CTRL_CS_LO];
  assign op_req         = req_q;
  assign tx_data        = din_q;

endmodule

// File: logic/sspim_ctl.sv
// Operation FSM; config is captured at start, one chip select is held low for the whole operation
`include "sspim_config.svh"

module sspim_ctl (
  input  logic                     mclk,
  input  logic                     reset_n,
  input  sspim_pkg::sspim_cfg_t    cfg,
  input  logic                     op_req,
  input  logic [31:0]              tx_data,
  input  sspim_pkg::sspim_edge_t   sck_edge,
  output logic                     op_done,
  output logic                     sck_en,
  output sspim_pkg::sspim_shift_t  shift,
  output logic [`SSPIM_NUM_CS-1:0] cs_n
);
  import sspim_pkg::*;

  sspim_state_e             state;
  sspim_cfg_t               cfg_q;
  logic [4:0]               cyc_cnt;
  logic [4:0]               bit_cnt;
  logic [4:0]               last_bit;
  logic [`SSPIM_NUM_CS-1:0] cs_dec;
  logic                     start;
  logic                     cyc_end;
  logic                     in_xfer;

  // ----------------------------------------------------------
  // Decodes
  // ----------------------------------------------------------
  // tx_data goes to the shifter on the same start edge
  assign start    = (state == st_idle) & op_req;
  assign cyc_end  = (cyc_cnt == cfg_q.cs_period);
  // Last bit index, 8 per byte
  assign last_bit = {cfg_q.xfer_size, 3'b111};
  assign in_xfer  = (state == st_xfer);

  // Active-low select from the live target field
  always_comb begin
    cs_dec = '1;
    cs_dec[cfg.tgt_sel] = 1'b0;
  end

  // ----------------------------------------------------------
  // State machine
  // ----------------------------------------------------------
  always_ff @(posedge mclk or negedge reset_n) begin
    if (!reset_n) begin
      state   <= st_idle;
      cfg_q   <= '0;
      cyc_cnt <= '0;
      bit_cnt <= '0;
      cs_n    <= '1;
    end else begin
      case (state)
        st_idle: begin
          if (op_req) begin
            state   <= st_cs_setup;
            cfg_q   <= cfg;
            cyc_cnt <= '0;
            cs_n    <= cs_dec;
          end
        end
        // cs_period+1 cycles before the first sck
        st_cs_setup: begin
          if (cyc_end) begin
            state   <= st_xfer;
            cyc_cnt <= '0;
            bit_cnt <= '0;
          end else begin
            cyc_cnt <= cyc_cnt + 5'd1;
          end
        end
        // Bits counted on falling sck
        st_xfer: begin
          if (sck_edge.sck_fall) begin
            if (bit_cnt == last_bit) begin
              state <= st_cs_hold;
            end else begin
              bit_cnt <= bit_cnt + 5'd1;
            end
          end
        end
        st_cs_hold: begin
          if (cyc_end) begin
            state <= st_done;
            cs_n  <= '1;
          end else begin
            cyc_cnt <= cyc_cnt + 5'd1;
          end
        end
        // Single cycle, clears the request bit
        st_done: begin
          state <= st_idle;
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // ----------------------------------------------------------
  // Outputs
  // ----------------------------------------------------------
  // sck runs only in st_xfer, so it stops low after the last fall
  assign sck_en          = in_xfer;
  assign op_done         = (state == st_done);
  assign shift.load      = start;
  assign shift.shift_out = in_xfer & sck_edge.sck_fall;
  // No capture for transmit-only
  assign shift.sample    = in_xfer & sck_edge.sck_rise & (cfg_q.op != op_wr);

endmodule

// File: logic/sspim_clkgen.sv
// sck divider for mode 0; half period is sck_period+1 mclk cycles and sck idles low when disabled
module sspim_clkgen (
  input  logic                   mclk,
  input  logic                   reset_n,
  input  logic [5:0]             sck_period,
  input  logic                   sck_en,
  output logic                   sck,
  output sspim_pkg::sspim_edge_t sck_edge
);

  logic [5:0] half_cnt;
  logic       toggle;

  // Toggle at the end of each half period
  assign toggle = sck_en & (half_cnt == sck_period);

  // ----------------------------------------------------------
  // Half-period counter and sck
  // ----------------------------------------------------------
  always_ff @(posedge mclk or negedge reset_n) begin
    if (!reset_n) begin
      half_cnt <= '0;
      sck      <= 1'b0;
    end else if (!sck_en) begin
      // Back to idle
      half_cnt <= '0;
      sck      <= 1'b0;
    end else if (toggle) begin
      half_cnt <= '0;
      sck      <= ~sck;
    end else begin
      half_cnt <= half_cnt + 6'd1;
    end
  end

  // ----------------------------------------------------------
  // Events
  // ----------------------------------------------------------
  // High in the cycle whose closing edge moves sck
  assign sck_edge.sck_rise = toggle & ~sck;
  assign sck_edge.sck_fall = toggle & sck;

endmodule

// File: logic/sspim_if.sv
// Shift registers for mode 0, MSB first; rx fills from bit 0 and is cleared at load except on op_wr
`include "sspim_config.svh"

module sspim_if (
  input  logic                    mclk,
  input  logic                    reset_n,
  input  sspim_pkg::sspim_shift_t shift,
  input  logic [31:0]             tx_data,
  input  logic [1:0]              xfer_size,
  input  sspim_pkg::sspim_op_e    op,
  input  logic                    miso,
  output logic                    mosi,
  output logic [31:0]             rx_data
);
  import sspim_pkg::*;

  logic [31:0] tx_sr;
  logic [31:0] tx_align;

  // Bytes moved up so bit 8n-1 lands on bit 31
  assign tx_align = tx_data << {~xfer_size, 3'b000};

  // ----------------------------------------------------------
  // Transmit side
  // ----------------------------------------------------------
  always_ff @(posedge mclk or negedge reset_n) begin
    if (!reset_n) begin
      tx_sr <= '0;
    end else if (shift.load) begin
      // Read-only sends zeros
      tx_sr <= (op == op_rd) ? '0 : tx_align;
    end else if (shift.shift_out) begin
      tx_sr <= {tx_sr[30:0], 1'b0};
    end
  end

  // First bit is out from load onward
  assign mosi = tx_sr[31];

  // ----------------------------------------------------------
  // Receive side
  // ----------------------------------------------------------
  always_ff @(posedge mclk or negedge reset_n) begin
    if (!reset_n) begin
      rx_data <= `SSPIM_DOUT_RST;
    end else if (shift.load) begin
      // Old data kept for transmit-only
      if (op != op_wr) begin
        rx_data <= '0;
      end
    end else if (shift.sample) begin
      rx_data <= {rx_data[30:0], miso};
    end
  end

endmodule

// File: logic/sspim_top.sv
// Single-bit SPI master, mode 0 only, four chip selects, no interrupt; software polls the request bit
`include "sspim_config.svh"

module sspim_top (
  input  logic                     mclk,
  input  logic                     reset_n,
  input  logic                     reg_cs,
  input  logic                     reg_wr,
  input  logic [7:0]               reg_addr,
  input  logic [31:0]              reg_wdata,
  input  logic [3:0]               reg_be,
  input  logic                     miso,
  output logic [31:0]              reg_rdata,
  output logic                     reg_ack,
  output logic                     sck,
  output logic                     mosi,
  output logic [`SSPIM_NUM_CS-1:0] cs_n
);
  import sspim_pkg::*;

  sspim_cfg_t   cfg;
  sspim_edge_t  sck_edge;
  sspim_shift_t shift;
  logic         op_req;
  logic         op_done;
  logic         sck_en;
  logic [31:0]  tx_data;
  logic [31:0]  rx_data;

  // ----------------------------------------------------------
  // Register block
  // ----------------------------------------------------------
  sspim_cfg u_cfg (
    .mclk      (mclk),
    .reset_n   (reset_n),
    .reg_cs    (reg_cs),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_be    (reg_be),
    .op_done   (op_done),
    .rx_data   (rx_data),
    .reg_rdata (reg_rdata),
    .reg_ack   (reg_ack),
    .cfg       (cfg),
    .op_req    (op_req),
    .tx_data   (tx_data)
  );

  // Operation control
  sspim_ctl u_ctl (
    .mclk     (mclk),
    .reset_n  (reset_n),
    .cfg      (cfg),
    .op_req   (op_req),
    .tx_data  (tx_data),
    .sck_edge (sck_edge),
    .op_done  (op_done),
    .sck_en   (sck_en),
    .shift    (shift),
    .cs_n     (cs_n)
  );

  // ----------------------------------------------------------
  // SPI side
  // ----------------------------------------------------------
  sspim_clkgen u_clkgen (
    .mclk       (mclk),
    .reset_n    (reset_n),
    .sck_period (cfg.sck_period),
    .sck_en     (sck_en),
    .sck        (sck),
    .sck_edge   (sck_edge)
  );

  // Size and op match the captured values at the load edge
  sspim_if u_if (
    .mclk      (mclk),
    .reset_n   (reset_n),
    .shift     (shift),
    .tx_data   (tx_data),
    .xfer_size (cfg.xfer_size),
    .op        (cfg.op),
    .miso      (miso),
    .mosi      (mosi),
    .rx_data   (rx_data)
  );

endmodule

// File: verification/tb_clock.sv
// Free-running mclk with a 40 unit period that starts low; no enable and no reset
module tb_clock (
  output logic mclk
);

  initial begin
    mclk = 1'b0;
  end

  // Half period of 20
  always begin
    #20 mclk = ~mclk;
  end

endmodule

// File: verification/sspim_assertions.sv
// Pin-level checks bound into sspim_top; all properties are ignored while reset_n is low
`include "sspim_config.svh"

module sspim_assertions (
  input logic                     mclk,
  input logic                     reset_n,
  input logic                     reg_ack,
  input logic [31:0]              reg_rdata,
  input logic                     sck,
  input logic                     mosi,
  input logic [`SSPIM_NUM_CS-1:0] cs_n
);

  // Failures seen so far, read by the testbench
  int fail_cnt = 0;

  // ----------------------------------------------------------
  // Chip select and sck
  // ----------------------------------------------------------
  a_one_cs: assert property (@(posedge mclk) disable iff (!reset_n)
    $countones(~cs_n) <= 1)
    else begin
      $error("More than one chip select line is low");
      fail_cnt++;
    end

  // sck parked low with nothing selected
  a_sck_idle: assert property (@(posedge mclk) disable iff (!reset_n)
    (&cs_n) |-> !sck)
    else begin
      $error("sck is high while no chip select is low");
      fail_cnt++;
    end

  // ----------------------------------------------------------
  // Register bus
  // ----------------------------------------------------------
  a_ack_pulse: assert property (@(posedge mclk) disable iff (!reset_n)
    reg_ack |=> !reg_ack)
    else begin
      $error("reg_ack stayed high for two cycles");
      fail_cnt++;
    end

  a_no_x: assert property (@(posedge mclk) disable iff (!reset_n)
    !$isunknown({reg_ack, reg_rdata, sck, mosi, cs_n}))
    else begin
      $error("An output of the SPI master is unknown after reset");
      fail_cnt++;
    end

endmodule

bind sspim_top sspim_assertions u_assertions (
  .mclk      (mclk),
  .reset_n   (reset_n),
  .reg_ack   (reg_ack),
  .reg_rdata (reg_rdata),
  .sck       (sck),
  .mosi      (mosi),
  .cs_n      (cs_n)
);

// File: verification/sspim_tb.sv
// Random mode 0 test with a slave model; uses op codes 0 to 2 only and polls the request bit
`include "sspim_config.svh"

module sspim_tb;
  import sspim_pkg::*;

  // Control bits 24:8 hold the fields
  localparam logic [31:0] ctrl_fields = 32'h01FF_FF00;
  localparam int          bus_limit   = 16;
  localparam int          poll_limit  = 5000;

  logic        mclk;
  logic        reset_n;
  logic        reg_cs;
  logic        reg_wr;
  logic [7:0]  reg_addr;
  logic [31:0] reg_wdata;
  logic [3:0]  reg_be;
  logic        miso;
  logic [31:0] reg_rdata;
  logic        reg_ack;
  logic        sck;
  logic        mosi;
  logic [3:0]  cs_n;

  integer      seed;
  // Register model
  logic [31:0] ctrl_model;
  logic [31:0] din_model;
  logic [31:0] dout_model;
  // Slave model state
  logic [31:0] slave_word;
  logic [31:0] miso_sr;
  logic [31:0] mosi_log;
  int          mosi_cnt;
  int          cs_starts;
  logic [3:0]  cs_seen;
  logic [3:0]  cs_prev;
  logic        sck_prev;
  // Expected results of the running operation
  logic [31:0] exp_mosi;
  int          exp_bits;
  int          exp_starts;
  logic [3:0]  exp_cs;

  tb_clock u_clock (
    .mclk (mclk)
  );

  sspim_top dut (
    .mclk      (mclk),
    .reset_n   (reset_n),
    .reg_cs    (reg_cs),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .reg_be    (reg_be),
    .miso      (miso),
    .reg_rdata (reg_rdata),
    .reg_ack   (reg_ack),
    .sck       (sck),
    .mosi      (mosi),
    .cs_n      (cs_n)
  );

  // ----------------------------------------------------------
  // Failure reporting
  // ----------------------------------------------------------
  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Run stopped");
  endtask

  task automatic compare_values(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Error: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      $display("Some tests failed");
      $fatal(1, "Mismatch in %s", name);
    end
  endtask

  // Stop on the first failed bound assertion
  always @(negedge mclk) begin
    if (dut.u_assertions.fail_cnt != 0) begin
      abort_run("A concurrent assertion on the DUT pins failed");
    end
  end

  // ----------------------------------------------------------
  // Register bus, driven on the falling edge
  // ----------------------------------------------------------
  task automatic bus_access(input logic wr, input logic [7:0] addr, input logic [31:0] wdata,
                            input logic [3:0] be, output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(negedge mclk);
    reg_cs    = 1'b1;
    reg_wr    = wr;
    reg_addr  = addr;
    reg_wdata = wdata;
    reg_be    = be;
    @(negedge mclk);
    while (reg_ack !== 1'b1) begin
      if (waited == bus_limit) begin
        abort_run("Register access got no reg_ack in time");
      end
      waited++;
      @(negedge mclk);
    end
    // Drop cs right after the ack cycle
    rdata  = reg_rdata;
    reg_cs = 1'b0;
    reg_wr = 1'b0;
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input logic [3:0] be);
    logic [31:0] unused;
    bus_access(1'b1, addr, data, be, unused);
  endtask

  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    bus_access(1'b0, addr, 32'h0, 4'hF, data);
  endtask

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = data[8*b +: 8];
      end
    end
    return res;
  endfunction

  function automatic logic [31:0] make_ctrl(input logic req, input logic [1:0] tgt,
                                            input logic [1:0] op, input logic [1:0] size,
                                            input logic [5:0] sckp, input logic [4:0] csp);
    logic [31:0] w;
    w = '0;
    w[`SSPIM_CTRL_REQ] = req;
    w[`SSPIM_CTRL_TGT_HI:`SSPIM_CTRL_TGT_LO]   = tgt;
    w[`SSPIM_CTRL_OP_HI:`SSPIM_CTRL_OP_LO]     = op;
    w[`SSPIM_CTRL_SIZE_HI:`SSPIM_CTRL_SIZE_LO] = size;
    w[`SSPIM_CTRL_SCK_HI:`SSPIM_CTRL_SCK_LO]   = sckp;
    w[`SSPIM_CTRL_CS_HI:`SSPIM_CTRL_CS_LO]     = csp;
    return w;
  endfunction

  // Idle read value by register index
  function automatic logic [31:0] expect_reg(input logic [1:0] idx);
    case (idx)
      2'd0:    return ctrl_model;
      2'd1:    return din_model;
      2'd2:    return dout_model;
      default: return 32'h0;
    endcase
  endfunction

  // ----------------------------------------------------------
  // SPI slave, mode 0, sampled on the falling mclk edge
  // ----------------------------------------------------------
  always @(negedge mclk) begin
    if (!(&cs_n) && (&cs_prev)) begin
      // Select seen, first bit goes out before the first rise
      cs_starts++;
      cs_seen  = cs_n;
      mosi_cnt = 0;
      mosi_log = '0;
      miso_sr  = slave_word;
    end else if (!(&cs_n)) begin
      if (sck && !sck_prev) begin
        mosi_log = {mosi_log[30:0], mosi};
        mosi_cnt++;
      end
      if (!sck && sck_prev) begin
        miso_sr = {miso_sr[30:0], 1'b0};
      end
    end else begin
      miso_sr = '0;
    end
    miso     = miso_sr[31];
    cs_prev  = cs_n;
    sck_prev = sck;
  end

  // ----------------------------------------------------------
  // Operations
  // ----------------------------------------------------------
  task automatic start_op(input sspim_op_e op, input logic [1:0] tgt, input logic [1:0] size,
                          input logic [5:0] sckp, input logic [4:0] csp,
                          input logic [31:0] data);
    int n;
    n          = size + 1;
    slave_word = $random(seed);
    exp_bits   = 8 * n;
    exp_starts = cs_starts + 1;
    exp_cs     = ~(4'b0001 << tgt);
    // n bytes from the low end of the data register
    exp_mosi   = (op == op_rd) ? 32'h0 : (data & (32'hFFFF_FFFF >> (32 - 8 * n)));
    if (op != op_wr) begin
      dout_model = slave_word >> (32 - 8 * n);
    end
    write_reg(`SSPIM_REG_DIN, data, 4'hF);
    din_model = data;
    write_reg(`SSPIM_REG_CTRL, make_ctrl(1'b1, tgt, op, size, sckp, csp), 4'hF);
    ctrl_model = make_ctrl(1'b0, tgt, op, size, sckp, csp);
  endtask

  task automatic finish_op(input string name);
    logic [31:0] rd;
    int          polls;
    polls = 0;
    read_reg(`SSPIM_REG_CTRL, rd);
    while (rd[`SSPIM_CTRL_REQ]) begin
      if (polls == poll_limit) begin
        abort_run("Request bit never cleared, the operation did not finish");
      end
      polls++;
      read_reg(`SSPIM_REG_CTRL, rd);
    end
    compare_values({name, " control"}, ctrl_model, rd);
    compare_values({name, " selects"}, exp_starts, cs_starts);
    compare_values({name, " cs_n"}, exp_cs, cs_seen);
    compare_values({name, " bit count"}, exp_bits, mosi_cnt);
    compare_values({name, " mosi"}, exp_mosi, mosi_log);
    read_reg(`SSPIM_REG_DOUT, rd);
    compare_values({name, " data out"}, dout_model, rd);
  endtask

  task automatic random_op(input sspim_op_e op, input string name);
    logic [31:0] r;
    logic [31:0] data;
    r    = $random(seed);
    data = $random(seed);
    start_op(op, r[1:0], r[3:2], r[9:4], r[14:10], data);
    finish_op(name);
  endtask

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    logic [31:0] r;
    logic [31:0] data;
    logic [31:0] rd;
    logic [7:0]  addr;
    seed       = 74;
    reset_n    = 1'b0;
    reg_cs     = 1'b0;
    reg_wr     = 1'b0;
    reg_addr   = '0;
    reg_wdata  = '0;
    reg_be     = '0;
    miso       = 1'b0;
    ctrl_model = '0;
    din_model  = '0;
    dout_model = '0;
    slave_word = '0;
    miso_sr    = '0;
    mosi_log   = '0;
    mosi_cnt   = 0;
    cs_starts  = 0;
    cs_seen    = 4'hF;
    cs_prev    = 4'hF;
    sck_prev   = 1'b0;
    // Eight rising edges in reset, released on a falling edge
    repeat (8) @(posedge mclk);
    @(negedge mclk);
    reset_n = 1'b1;

    // Every register zero after reset
    for (int i = 0; i < 4; i++) begin
      read_reg(8'(4 * i), rd);
      compare_values("reset value", 32'h0, rd);
    end

    // Random byte-enabled writes, request bit kept clear
    for (int i = 0; i < 24; i++) begin
      r    = $random(seed);
      data = $random(seed);
      data[`SSPIM_CTRL_REQ] = 1'b0;
      addr = {4'h0, r[1:0], 2'b00};
      write_reg(addr, data, r[7:4]);
      if (r[1:0] == 2'd0) begin
        ctrl_model = merge_bytes(ctrl_model, data & ctrl_fields, r[7:4]);
      end else if (r[1:0] == 2'd1) begin
        din_model = merge_bytes(din_model, data, r[7:4]);
      end
      read_reg(addr, rd);
      compare_values("register readback", expect_reg(r[1:0]), rd);
    end

    // Reads first so the write test sees a nonzero data out
    for (int i = 0; i < 6; i++) begin
      random_op(op_rd, "read op");
    end
    for (int i = 0; i < 6; i++) begin
      random_op(op_wr, "write op");
    end
    for (int i = 0; i < 20; i++) begin
      random_op(op_wr_rd, "full duplex op");
    end

    // Busy flag, writes during an operation, zero write to request
    r    = $random(seed);
    data = $random(seed);
    start_op(op_wr_rd, r[1:0], 2'd3, 6'd4 + r[5:2], r[10:6], data);
    read_reg(`SSPIM_REG_CTRL, rd);
    compare_values("busy request bit", 32'h1, rd[`SSPIM_CTRL_REQ]);
    data = $random(seed);
    write_reg(`SSPIM_REG_DIN, data, 4'hF);
    din_model = data;
    // Other target, op and size with the request bit clear
    ctrl_model = make_ctrl(1'b0, r[1:0] + 2'd1, op_wr, 2'd0, r[15:10], r[20:16]);
    write_reg(`SSPIM_REG_CTRL, ctrl_model, 4'hF);
    read_reg(`SSPIM_REG_CTRL, rd);
    compare_values("request after zero write", ctrl_model | 32'h8000_0000, rd);
    finish_op("write during op");
    read_reg(`SSPIM_REG_DIN, rd);
    compare_values("data in after op", din_model, rd);

    if (dut.u_assertions.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: src.f
+incdir+logic
logic/sspim_pkg.sv
logic/sspim_cfg.sv
logic/sspim_ctl.sv
logic/sspim_clkgen.sv
logic/sspim_if.sv
logic/sspim_top.sv
verification/tb_clock.sv
verification/sspim_assertions.sv
verification/sspim_tb.sv
